//--- hw/fft_cfg_pkg.sv
package fft_cfg_pkg;

    ////////////////////
    // Sizes

    localparam int MAX_LOG2_N  = 4;
    localparam int MIN_LOG2_N  = 2;
    localparam int LOG2_N_W    = 3;
    localparam int IDX_W       = MAX_LOG2_N;
    localparam int FRAME_CNT_W = 4;

    typedef logic [LOG2_N_W-1:0] log2_n_t;
    typedef logic [IDX_W-1:0]    idx_t;

    typedef struct packed {
        logic    ifft;
        log2_n_t log2_n;
    } fft_cfg_t;

    // Forward transform at full size
    localparam fft_cfg_t CFG_RESET = '{ifft: 1'b0, log2_n: log2_n_t'(MAX_LOG2_N)};

    // Final sample count of a frame, bad sizes fall back to the largest
    function automatic idx_t last_idx(log2_n_t log2_n);
        int n;
        if (log2_n < MIN_LOG2_N || log2_n > MAX_LOG2_N) begin
            n = MAX_LOG2_N;
        end else begin
            n = int'(log2_n);
        end
        return idx_t'((1 << n) - 1);
    endfunction

endpackage

//--- hw/fft_sample_pkg.sv
package fft_sample_pkg;

    localparam int DATA_W = 16;

    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } sample_t;

    ////////////////////
    // Stream beats

    typedef struct packed {
        logic    start;
        logic    valid;
        sample_t sample;
    } beat_t;

    // Reordered output carries its bit-reversed position
    typedef struct packed {
        beat_t             beat;
        fft_cfg_pkg::idx_t idx;
    } out_beat_t;

endpackage

//--- hw/fft_mode_ctrl.sv
`timescale 1ns/1ps

module fft_mode_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_valid_i,
    input  fft_cfg_pkg::fft_cfg_t cfg_i,
    input  logic                  frame_start_i,
    input  logic                  frame_end_i,
    output logic                  start_en_o,
    output logic                  active_ifft_o,
    output fft_cfg_pkg::log2_n_t  active_log2_n_o
);

    import fft_cfg_pkg::*;

    fft_cfg_t               cfg_lock;
    fft_cfg_t               cfg_active;
    logic [FRAME_CNT_W-1:0] frames;
    logic                   idle;
    logic                   start_en;

    assign idle = (frames == '0);

    // Latest request, held until the pipeline drains
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_lock <= CFG_RESET;
        end else if (cfg_valid_i) begin
            cfg_lock <= cfg_i;
        end
    end

    ////////////////////
    // Frames in flight

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frames <= '0;
        end else begin
            case ({frame_start_i, frame_end_i})
                2'b10:   frames <= frames + 1'b1;
                2'b01:   frames <= frames - 1'b1;
                default: frames <= frames;
            endcase
        end
    end

    // Hold off new frames while a reconfiguration waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_en <= 1'b1;
        end else if (idle) begin
            start_en <= 1'b1;
        end else if (cfg_valid_i) begin
            start_en <= 1'b0;
        end
    end

    // Mode only switches with an empty pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_active <= CFG_RESET;
        end else if (idle) begin
            cfg_active <= cfg_lock;
        end
    end

    assign start_en_o      = start_en;
    assign active_ifft_o   = cfg_active.ifft;
    assign active_log2_n_o = cfg_active.log2_n;

endmodule

//--- hw/fft_input_cond.sv
`timescale 1ns/1ps

module fft_input_cond (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fft_sample_pkg::beat_t beat_i,
    input  logic                  ifft_i,
    output fft_sample_pkg::beat_t beat_o
);

    import fft_sample_pkg::*;

    sample_t src;

    // Inverse transform runs through the forward pipeline with parts swapped
    always_comb begin
        if (ifft_i) begin
            src.re = beat_i.sample.im;
            src.im = beat_i.sample.re;
        end else begin
            src = beat_i.sample;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_o <= '0;
        end else begin
            beat_o.start <= beat_i.start;
            beat_o.valid <= beat_i.valid;
            // Halve to leave headroom for the butterflies
            beat_o.sample.re <= src.re >>> 1;
            beat_o.sample.im <= src.im >>> 1;
        end
    end

endmodule

//--- hw/fft_output_reorder.sv
`timescale 1ns/1ps

module fft_output_reorder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fft_sample_pkg::beat_t     beat_i,
    input  logic                      ifft_i,
    input  fft_cfg_pkg::log2_n_t      log2_n_i,
    output fft_sample_pkg::out_beat_t beat_o,
    output logic                      frame_end_o
);

    import fft_cfg_pkg::*;
    import fft_sample_pkg::*;

    idx_t    cnt;
    idx_t    last_cnt;
    idx_t    cnt_rev;
    idx_t    rev_idx;
    logic    frame_end;
    sample_t restored;

    assign last_cnt  = last_idx(log2_n_i);
    assign frame_end = beat_i.valid && (cnt == last_cnt);

    ////////////////////
    // Sample counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (beat_i.valid) begin
            if (frame_end) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Reverse all bits, then drop the ones beyond the active size
    always_comb begin
        cnt_rev = '0;
        for (int b = 0; b < IDX_W; b++) begin
            cnt_rev[b] = cnt[IDX_W-1-b];
        end
    end

    // last_cnt has exactly log2_n ones
    assign rev_idx = cnt_rev >> (IDX_W - $countones(last_cnt));

    // Undo the input swap, no rescaling here
    always_comb begin
        if (ifft_i) begin
            restored.re = beat_i.sample.im;
            restored.im = beat_i.sample.re;
        end else begin
            restored = beat_i.sample;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_o <= '0;
        end else begin
            beat_o.beat.valid  <= beat_i.valid;
            beat_o.beat.start  <= beat_i.start && (cnt == '0);
            beat_o.beat.sample <= restored;
            beat_o.idx         <= rev_idx;
        end
    end

    assign frame_end_o = frame_end;

endmodule

//--- hw/fft_ctrl_top.sv
`timescale 1ns/1ps

module fft_ctrl_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_valid_i,
    input  fft_cfg_pkg::fft_cfg_t     cfg_i,
    output logic                      start_en_o,
    input  fft_sample_pkg::beat_t     in_beat_i,
    output fft_sample_pkg::beat_t     stage_beat_o,
    output fft_cfg_pkg::log2_n_t      log2_n_o,
    input  fft_sample_pkg::beat_t     ret_beat_i,
    output fft_sample_pkg::out_beat_t out_beat_o
);

    import fft_cfg_pkg::*;

    logic    active_ifft;
    log2_n_t active_log2_n;
    logic    frame_end;

    ////////////////////
    // Mode control

    fft_mode_ctrl u_mode (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_valid_i     (cfg_valid_i),
        .cfg_i           (cfg_i),
        .frame_start_i   (in_beat_i.start),
        .frame_end_i     (frame_end),
        .start_en_o      (start_en_o),
        .active_ifft_o   (active_ifft),
        .active_log2_n_o (active_log2_n)
    );

    // Toward the FFT stages
    fft_input_cond u_in (
        .clk    (clk),
        .rst_n  (rst_n),
        .beat_i (in_beat_i),
        .ifft_i (active_ifft),
        .beat_o (stage_beat_o)
    );

    // Back from stage 0
    fft_output_reorder u_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat_i      (ret_beat_i),
        .ifft_i      (active_ifft),
        .log2_n_i    (active_log2_n),
        .beat_o      (out_beat_o),
        .frame_end_o (frame_end)
    );

    assign log2_n_o = active_log2_n;

endmodule

//--- verif/fft_ctrl_checker.sv
`timescale 1ns/1ps

module fft_ctrl_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_valid_i,
    input  fft_cfg_pkg::fft_cfg_t     cfg_i,
    input  logic                      start_en_i,
    input  fft_sample_pkg::beat_t     in_beat_i,
    input  fft_sample_pkg::beat_t     stage_beat_i,
    input  fft_cfg_pkg::log2_n_t      log2_n_i,
    input  fft_sample_pkg::beat_t     ret_beat_i,
    input  fft_sample_pkg::out_beat_t out_beat_i,
    output int                        error_cnt_o,
    output int                        check_cnt_o
);

    import fft_cfg_pkg::*;
    import fft_sample_pkg::*;

    fft_cfg_t  lock_m;
    fft_cfg_t  active_m;
    int        frames_m;
    idx_t      cnt_m;
    logic      start_en_m;
    beat_t     exp_stage;
    out_beat_t exp_out;
    int        errors = 0;
    int        checks = 0;

    // Points per frame, unknown sizes run as 16
    function automatic int frame_len(log2_n_t l);
        if (l >= 3'd2 && l <= 3'd4) begin
            return 1 << l;
        end
        return 16;
    endfunction

    // Floor of x/2
    function automatic logic signed [DATA_W-1:0] halve(logic signed [DATA_W-1:0] x);
        int v;
        v = int'(x);
        return DATA_W'((v - (v & 1)) / 2);
    endfunction

    function automatic idx_t bitrev(idx_t c, int bits);
        idx_t r;
        r = '0;
        for (int b = 0; b < bits; b++) begin
            r[b] = c[bits-1-b];
        end
        return r;
    endfunction

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s at %0t: expected %h actual %h", name, $time, exp, act);
        end
    endtask

    ////////////////////
    // Reference model

    always @(posedge clk or negedge rst_n) begin : model
        int   len;
        logic fend;
        if (!rst_n) begin
            lock_m     = '{ifft: 1'b0, log2_n: 3'd4};
            active_m   = lock_m;
            frames_m   = 0;
            cnt_m      = '0;
            start_en_m = 1'b1;
            exp_stage  = '0;
            exp_out    = '0;
        end else begin
            len  = frame_len(active_m.log2_n);
            fend = ret_beat_i.valid && (int'(cnt_m) == len - 1);

            exp_stage.start = in_beat_i.start;
            exp_stage.valid = in_beat_i.valid;
            if (active_m.ifft) begin
                exp_stage.sample.re = halve(in_beat_i.sample.im);
                exp_stage.sample.im = halve(in_beat_i.sample.re);
            end else begin
                exp_stage.sample.re = halve(in_beat_i.sample.re);
                exp_stage.sample.im = halve(in_beat_i.sample.im);
            end

            exp_out.beat.valid = ret_beat_i.valid;
            exp_out.beat.start = ret_beat_i.start && (cnt_m == '0);
            exp_out.beat.sample.re = active_m.ifft ? ret_beat_i.sample.im : ret_beat_i.sample.re;
            exp_out.beat.sample.im = active_m.ifft ? ret_beat_i.sample.re : ret_beat_i.sample.im;
            exp_out.idx = bitrev(cnt_m, $clog2(len));
            if (ret_beat_i.valid) begin
                cnt_m = fend ? '0 : cnt_m + 1'b1;
            end

            // Old lock goes active, new request only lands in the lock
            if (frames_m == 0) begin
                active_m   = lock_m;
                start_en_m = 1'b1;
            end else if (cfg_valid_i) begin
                start_en_m = 1'b0;
            end
            if (cfg_valid_i) begin
                lock_m = cfg_i;
            end

            frames_m = frames_m + int'(in_beat_i.start) - int'(fend);
            if (frames_m < 0) begin
                errors++;
                $display("Returned stream ended a frame that was never started at %0t", $time);
                frames_m = 0;
            end
        end
    end

    // Registered outputs are settled by the falling edge
    always @(negedge clk) begin
        check_value("start_en_o", 64'(start_en_m), 64'(start_en_i));
        check_value("log2_n_o", 64'(active_m.log2_n), 64'(log2_n_i));
        check_value("stage_beat_o", 64'(exp_stage), 64'(stage_beat_i));
        check_value("out_beat_o", 64'(exp_out), 64'(out_beat_i));
    end

    assign error_cnt_o = errors;
    assign check_cnt_o = checks;

endmodule

//--- verif/fft_ctrl_tb.sv
`timescale 1ns/1ps

module fft_ctrl_tb;

    import fft_cfg_pkg::*;
    import fft_sample_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int MARGIN       = 50;

    typedef struct packed {
        logic     cfg_valid;
        fft_cfg_t cfg;
        beat_t    in_beat;
        beat_t    ret_beat;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      cfg_valid;
    fft_cfg_t  cfg;
    beat_t     in_beat;
    beat_t     ret_beat;
    logic      start_en;
    beat_t     stage_beat;
    log2_n_t   log2_n;
    out_beat_t out_beat;
    int        error_cnt;
    int        check_cnt;
    row_t      rows[$];
    int        cycles = 0;
    int        limit = 1000;

    fft_ctrl_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_valid_i  (cfg_valid),
        .cfg_i        (cfg),
        .start_en_o   (start_en),
        .in_beat_i    (in_beat),
        .stage_beat_o (stage_beat),
        .log2_n_o     (log2_n),
        .ret_beat_i   (ret_beat),
        .out_beat_o   (out_beat)
    );

    fft_ctrl_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_valid_i  (cfg_valid),
        .cfg_i        (cfg),
        .start_en_i   (start_en),
        .in_beat_i    (in_beat),
        .stage_beat_i (stage_beat),
        .log2_n_i     (log2_n),
        .ret_beat_i   (ret_beat),
        .out_beat_i   (out_beat),
        .error_cnt_o  (error_cnt),
        .check_cnt_o  (check_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Random parts, with the extremes near the start of each frame
    function automatic sample_t make_sample(int i);
        sample_t s;
        s.re = DATA_W'($urandom);
        s.im = DATA_W'($urandom);
        if (i == 1) begin
            s.re = 16'h7fff;
            s.im = 16'h8000;
        end else if (i == 2) begin
            s.re = 16'hffff;
            s.im = 16'h0001;
        end
        return s;
    endfunction

    ////////////////////
    // Table building

    task automatic add_idle(int n);
        row_t r;
        r = '0;
        repeat (n) rows.push_back(r);
    endtask

    task automatic add_cfg(logic ifft, log2_n_t l2);
        row_t r;
        r = '0;
        r.cfg_valid = 1'b1;
        r.cfg.ifft = ifft;
        r.cfg.log2_n = l2;
        rows.push_back(r);
    endtask

    // Source frame, a spacer row, then the stage 0 return
    task automatic add_frame(int n, bit gaps, bit cfg_mid, fft_cfg_t mid_cfg);
        row_t r;
        for (int i = 0; i < n; i++) begin
            r = '0;
            r.in_beat.valid = 1'b1;
            r.in_beat.start = (i == 0);
            r.in_beat.sample = make_sample(i);
            rows.push_back(r);
        end
        r = '0;
        if (cfg_mid) begin
            r.cfg_valid = 1'b1;
            r.cfg = mid_cfg;
        end
        rows.push_back(r);
        for (int i = 0; i < n; i++) begin
            if (gaps && (i % 3 == 2)) begin
                r = '0;
                rows.push_back(r);
            end
            r = '0;
            r.ret_beat.valid = 1'b1;
            // Gapped frames also carry a stray start mid-frame
            r.ret_beat.start = (i == 0) || (gaps && (i == n / 2));
            r.ret_beat.sample = make_sample(i + 3);
            rows.push_back(r);
        end
    endtask

    task automatic apply_row(row_t r);
        cfg_valid = r.cfg_valid;
        cfg = r.cfg;
        in_beat = r.in_beat;
        ret_beat = r.ret_beat;
    endtask

    initial begin
        fft_cfg_t fwd16;
        void'($urandom(32'h3cb1_2a18));
        rst_n = 1'b0;
        cfg_valid = 1'b0;
        cfg = '0;
        in_beat = '0;
        ret_beat = '0;
        fwd16 = '{ifft: 1'b0, log2_n: 3'd4};

        add_idle(2);
        add_frame(16, 1'b0, 1'b0, fwd16);
        add_cfg(1'b0, 3'd2);
        add_idle(3);
        add_frame(4, 1'b1, 1'b0, fwd16);
        add_cfg(1'b0, 3'd3);
        add_idle(2);
        add_frame(8, 1'b1, 1'b0, fwd16);
        add_cfg(1'b1, 3'd3);
        add_idle(2);
        add_frame(8, 1'b0, 1'b0, fwd16);
        // Reconfigure back to forward 16 while this frame is in flight
        add_frame(8, 1'b0, 1'b1, fwd16);
        add_idle(3);
        add_frame(16, 1'b1, 1'b0, fwd16);
        add_cfg(1'b0, 3'd7);
        add_idle(2);
        add_frame(16, 1'b0, 1'b0, fwd16);
        add_idle(3);
        limit = rows.size() + RESET_CYCLES + MARGIN;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            apply_row(rows[i]);
        end
        @(negedge clk);
        apply_row('0);
        repeat (2) @(negedge clk);
        #1;

        if (check_cnt == 0) begin
            $display("Checker compared no DUT outputs");
        end
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0 && check_cnt > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

//--- sources.f
hw/fft_cfg_pkg.sv
hw/fft_sample_pkg.sv
hw/fft_mode_ctrl.sv
hw/fft_input_cond.sv
hw/fft_output_reorder.sv
hw/fft_ctrl_top.sv
verif/fft_ctrl_checker.sv
verif/fft_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module fft_ctrl_tb \
    -f sources.f -o fft_ctrl_sim

./obj_dir/fft_ctrl_sim | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
